/* core_pkg.sv */
package core_pkg;

   localparam int xlen_p = 32;
   localparam int reg_addr_w = 5;
   localparam int imm_w = 11;
   localparam int prog_depth_def = 64;           // Default program store depth
   localparam int pc_w = $clog2(prog_depth_def);
   localparam int mul_stages = 5;

   typedef logic [reg_addr_w-1:0] reg_idx_t;
   typedef logic [xlen_p-1:0]     word_t;
   typedef logic [pc_w-1:0]       pc_t;

   typedef enum logic [5:0] {
      op_nop  = 6'd0,
      op_add  = 6'd1,
      op_sub  = 6'd2,
      op_and  = 6'd3,
      op_or   = 6'd4,
      op_addi = 6'd5,
      op_mul  = 6'd6,
      op_halt = 6'd7
   } opcode_e;

   typedef struct packed {
      opcode_e                  op;
      reg_idx_t                 rd;
      reg_idx_t                 rs;
      reg_idx_t                 rt;
      logic signed [imm_w-1:0]  imm;
   } instr_t;

   typedef struct packed {
      logic    valid;
      pc_t     addr;
      instr_t  instr;
   } prog_wr_t;

   typedef struct packed {
      logic     valid;
      opcode_e  op;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    a;
      word_t    b;
      logic     b_imm;   // b already holds the extended immediate
   } ex_req_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } wb_t;

   // Ops executed in the single-cycle ALU
   function automatic logic op_is_alu(opcode_e op);
      return op inside {op_add, op_sub, op_and, op_or, op_addi};
   endfunction

   function automatic logic op_writes(opcode_e op);
      return op_is_alu(op) || (op == op_mul);
   endfunction

   function automatic logic op_reads_rs(opcode_e op);
      return op_writes(op);
   endfunction

   function automatic logic op_reads_rt(opcode_e op);
      return op inside {op_add, op_sub, op_and, op_or, op_mul};
   endfunction

endpackage

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
   input  logic     clk,
   input  logic     if_id_reset,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  wb_t      wr,
   output word_t    rdata_s,
   output word_t    rdata_t
);

   localparam int nregs = 2 ** reg_addr_w;

   word_t regs [nregs];

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         regs <= '{default: '0};
      end else if (wr.valid && (wr.rd != '0)) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // Write-through, so decode sees this cycle's write-back
   always_comb begin
      if (rs == '0) rdata_s = '0;
      else if (wr.valid && (wr.rd == rs)) rdata_s = wr.data;
      else rdata_s = regs[rs];
   end

   always_comb begin
      if (rt == '0) rdata_t = '0;
      else if (wr.valid && (wr.rd == rt)) rdata_t = wr.data;
      else rdata_t = regs[rt];
   end

endmodule

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import core_pkg::*; #(
   parameter int prog_depth_p = prog_depth_def
) (
   input  logic     clk,
   input  logic     if_id_reset,
   input  prog_wr_t prog,
   input  logic     start,
   input  logic     stall,
   output instr_t   fetched,
   output logic     fetched_valid,
   output logic     halt_seen
);

   instr_t store [prog_depth_p];   // Program store, loaded by the testbench
   pc_t    pc;
   logic   running;
   instr_t word;

   always_ff @(posedge clk) begin
      if (prog.valid) begin
         store[prog.addr] <= prog.instr;
      end
   end

   assign word = store[pc];

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pc            <= '0;
         running       <= 1'b0;
         fetched_valid <= 1'b0;
         halt_seen     <= 1'b0;
      end else if (start) begin
         pc            <= '0;
         running       <= 1'b1;
         fetched_valid <= 1'b0;   // Drop anything left from an earlier run
         halt_seen     <= 1'b0;
      end else if (!stall) begin
         fetched_valid <= running;
         if (running) begin
            pc <= (pc == pc_t'(prog_depth_p - 1)) ? '0 : pc + 1'b1;
            // Halt stops fetch once it sits in the fetch/decode register
            if (word.op == op_halt) begin
               running   <= 1'b0;
               halt_seen <= 1'b1;
            end
         end
      end
   end

   // Fetch/decode payload
   always_ff @(posedge clk) begin
      if (!stall) begin
         fetched <= word;
      end
   end

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import core_pkg::*; (
   input  logic    clk,
   input  logic    if_id_reset,
   input  instr_t  fetched,
   input  logic    fetched_valid,
   input  logic    stall,
   input  wb_t     wr,
   output ex_req_t issued
);

   word_t rdata_s;
   word_t rdata_t;
   word_t imm_ext;
   logic  use_imm;

   reg_file u_reg_file (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .rs          (fetched.rs),
      .rt          (fetched.rt),
      .wr          (wr),
      .rdata_s     (rdata_s),
      .rdata_t     (rdata_t)
   );

   assign imm_ext = {{(xlen_p - imm_w){fetched.imm[imm_w-1]}}, fetched.imm};
   assign use_imm = (fetched.op == op_addi);

   // Decode/execute register
   always_ff @(posedge clk) begin
      issued.op    <= fetched.op;
      issued.rd    <= fetched.rd;
      issued.rs    <= fetched.rs;
      issued.rt    <= fetched.rt;
      issued.a     <= rdata_s;
      issued.b     <= use_imm ? imm_ext : rdata_t;
      issued.b_imm <= use_imm;
      if (if_id_reset) begin
         issued.valid <= 1'b0;
      end else begin
         issued.valid <= fetched_valid && !stall;   // Stall sends a bubble
      end
   end

endmodule

/* issue_control.sv */
`timescale 1ns/100ps

module issue_control import core_pkg::*; (
   input  instr_t                 dec,
   input  logic                   dec_valid,
   input  wb_t [mul_stages-1:0]   mult_busy_regs,
   input  wb_t                    alu_wb,
   input  ex_req_t                ex_req,
   output logic                   stall,
   output logic                   fwd_a,
   output logic                   fwd_b
);

   // Third multiply stage, two cycles from write-back like a decoded ALU op
   localparam int clash_stage = 2;

   logic src_hit;
   logic dst_hit;
   logic wb_clash;

   always_comb begin
      src_hit = 1'b0;
      dst_hit = 1'b0;
      for (int k = 0; k < mul_stages; k++) begin
         if (mult_busy_regs[k].valid) begin
            if (op_reads_rs(dec.op) && (dec.rs == mult_busy_regs[k].rd)) begin
               src_hit = 1'b1;
            end
            if (op_reads_rt(dec.op) && (dec.rt == mult_busy_regs[k].rd)) begin
               src_hit = 1'b1;
            end
            // Same destination, keep the writes in order
            if (op_writes(dec.op) && (dec.rd == mult_busy_regs[k].rd)) begin
               dst_hit = 1'b1;
            end
         end
      end
   end

   assign wb_clash = op_is_alu(dec.op) && mult_busy_regs[clash_stage].valid;

   assign stall = dec_valid && (src_hit || dst_hit || wb_clash);

   // ALU result one instruction ahead, not yet in the register file
   assign fwd_a = ex_req.valid && alu_wb.valid && op_reads_rs(ex_req.op)
                  && (alu_wb.rd == ex_req.rs);
   assign fwd_b = ex_req.valid && alu_wb.valid && op_reads_rt(ex_req.op)
                  && !ex_req.b_imm && (alu_wb.rd == ex_req.rt);

endmodule

/* alu_stage.sv */
`timescale 1ns/100ps

module alu_stage import core_pkg::*; (
   input  logic    clk,
   input  logic    if_id_reset,
   input  ex_req_t req,
   input  logic    fwd_a,
   input  logic    fwd_b,
   output wb_t     alu_wb
);

   word_t op_a;
   word_t op_b;
   word_t result;
   logic  take;

   // Forward from our own write-back register
   assign op_a = fwd_a ? alu_wb.data : req.a;
   assign op_b = fwd_b ? alu_wb.data : req.b;

   always_comb begin
      case (req.op)
         op_add,
         op_addi: result = op_a + op_b;
         op_sub:  result = op_a - op_b;
         op_and:  result = op_a & op_b;
         op_or:   result = op_a | op_b;
         default: result = '0;
      endcase
   end

   // Mul goes to the multiply pipe, halt and nop write nothing
   assign take = req.valid && op_is_alu(req.op) && (req.rd != '0);

   always_ff @(posedge clk) begin
      alu_wb.rd   <= req.rd;
      alu_wb.data <= result;
      if (if_id_reset) begin
         alu_wb.valid <= 1'b0;
      end else begin
         alu_wb.valid <= take;
      end
   end

endmodule

/* mult_pipe.sv */
`timescale 1ns/100ps

module mult_pipe import core_pkg::*; (
   input  logic                 clk,
   input  logic                 if_id_reset,
   input  ex_req_t              req,
   output wb_t [mul_stages-1:0] mult_busy_regs,
   output wb_t                  mul_wb
);

   localparam int slice_w = 8;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    a;
      word_t    b;
      word_t    acc;   // Sum of the slices added so far
   } mstage_t;

   mstage_t stg [mul_stages];

   // Stage one takes the operands straight off the decode/execute register
   always_comb begin
      stg[0].valid = req.valid && (req.op == op_mul) && (req.rd != '0);
      stg[0].rd    = req.rd;
      stg[0].a     = req.a;
      stg[0].b     = req.b;
      stg[0].acc   = '0;
   end

   // Each later stage adds one byte slice of b times a
   for (genvar g = 1; g < mul_stages; g++) begin : g_stage
      word_t part;

      assign part = (stg[g-1].a * word_t'(stg[g-1].b[slice_w*(g-1) +: slice_w]))
                    << (slice_w * (g - 1));

      always_ff @(posedge clk) begin
         stg[g].rd  <= stg[g-1].rd;
         stg[g].a   <= stg[g-1].a;
         stg[g].b   <= stg[g-1].b;
         stg[g].acc <= stg[g-1].acc + part;   // Low 32 bits only
         if (if_id_reset) begin
            stg[g].valid <= 1'b0;
         end else begin
            stg[g].valid <= stg[g-1].valid;
         end
      end
   end

   // Destinations in flight for the stall logic
   always_comb begin
      for (int k = 0; k < mul_stages; k++) begin
         mult_busy_regs[k].valid = stg[k].valid;
         mult_busy_regs[k].rd    = stg[k].rd;
         mult_busy_regs[k].data  = '0;
      end
   end

   assign mul_wb.valid = stg[mul_stages-1].valid;
   assign mul_wb.rd    = stg[mul_stages-1].rd;
   assign mul_wb.data  = stg[mul_stages-1].acc;

endmodule

/* core_top.sv */
`timescale 1ns/100ps

module core_top import core_pkg::*; #(
   parameter int prog_depth_p = prog_depth_def
) (
   input  logic     clk,
   input  logic     if_id_reset,
   input  prog_wr_t prog,
   input  logic     start,
   output logic     busy,
   output wb_t      wb
);

   instr_t               fetched;
   logic                 fetched_valid;
   logic                 halt_seen;
   logic                 stall;
   logic                 fwd_a;
   logic                 fwd_b;
   logic                 any_valid;
   ex_req_t              issued;
   ex_req_t              mul_req;
   wb_t                  alu_wb;
   wb_t                  mul_wb;
   wb_t [mul_stages-1:0] mult_busy_regs;

   fetch_stage #(.prog_depth_p(prog_depth_p)) u_fetch (
      .clk(clk), .if_id_reset(if_id_reset), .prog(prog), .start(start), .stall(stall),
      .fetched(fetched), .fetched_valid(fetched_valid), .halt_seen(halt_seen)
   );

   decode_stage u_decode (
      .clk(clk), .if_id_reset(if_id_reset), .fetched(fetched),
      .fetched_valid(fetched_valid), .stall(stall), .wr(wb), .issued(issued)
   );

   issue_control u_issue (
      .dec(fetched), .dec_valid(fetched_valid), .mult_busy_regs(mult_busy_regs),
      .alu_wb(alu_wb), .ex_req(issued), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

   alu_stage u_alu (
      .clk(clk), .if_id_reset(if_id_reset), .req(issued),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .alu_wb(alu_wb)
   );

   // A mul right behind a dependent ALU op needs the same forwarded operands
   always_comb begin
      mul_req = issued;
      if (fwd_a) mul_req.a = alu_wb.data;
      if (fwd_b) mul_req.b = alu_wb.data;
   end

   mult_pipe u_mult (
      .clk(clk), .if_id_reset(if_id_reset), .req(mul_req),
      .mult_busy_regs(mult_busy_regs), .mul_wb(mul_wb)
   );

   assign wb = alu_wb.valid ? alu_wb : mul_wb;   // Never both valid

   always_comb begin
      any_valid = fetched_valid | issued.valid | alu_wb.valid;
      for (int k = 0; k < mul_stages; k++) begin
         any_valid = any_valid | mult_busy_regs[k].valid;
      end
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) busy <= 1'b0;
      else if (start) busy <= 1'b1;
      else if (halt_seen && !any_valid) busy <= 1'b0;   // Drained after halt
   end

endmodule

/* core_checker.sv */
`timescale 1ns/100ps

module core_checker import core_pkg::*; (
   input logic clk,
   input logic if_id_reset,
   input logic start,
   input logic busy,
   input wb_t  wb
);

   // Results only come out of a running program
   a_wb_while_busy: assert property (
      @(posedge clk) disable iff (if_id_reset) wb.valid |-> busy
   ) else $error("write-back strobe with busy low");

   // Register 0 writes are dropped before write-back
   a_wb_not_r0: assert property (
      @(posedge clk) disable iff (if_id_reset) wb.valid |-> (wb.rd != '0)
   ) else $error("write-back strobe for register 0");

   a_busy_after_start: assert property (
      @(posedge clk) disable iff (if_id_reset) start |=> busy
   ) else $error("busy not raised in the cycle after start");

endmodule

/* tb_core.sv */
`timescale 1ns/100ps

module tb_core import core_pkg::*; ();

   logic     clk;
   logic     if_id_reset;
   prog_wr_t prog;
   logic     start;
   logic     busy;
   wb_t      wb;

   instr_t prog_buf [64];
   int     prog_len;
   word_t  model_regs [32] = '{default: '0};   // Reference register state
   wb_t    exp_q [$];                          // Expected writes, program order
   int     n_value_err;
   int     n_other_err;
   int     cycle_cnt;
   int     cycle_limit = 50;                   // Reset and idle check, grows per program
   int     seed;

   core_top #(.prog_depth_p(64)) dut (
      .clk(clk), .if_id_reset(if_id_reset), .prog(prog), .start(start),
      .busy(busy), .wb(wb)
   );

   bind core_top core_checker u_checker (
      .clk(clk), .if_id_reset(if_id_reset), .start(start), .busy(busy), .wb(wb)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_wb(input string what, input wb_t got, input wb_t exp);
      if (got.valid !== exp.valid) begin
         n_value_err++;
         $display("FAIL %s.valid got %h exp %h", what, got.valid, exp.valid);
      end else if (exp.valid && (got.data !== exp.data)) begin
         n_value_err++;
         $display("FAIL %s.data got %h exp %h (rd %h)", what, got.data, exp.data, exp.rd);
      end
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp) begin
         n_value_err++;
         $display("FAIL busy got %h exp %h", got, exp);
      end
   endtask

   // Sequential reference, one instruction at a time
   task automatic put_instr(input opcode_e op, input int rd, input int rs, input int rt,
                            input int imm);
      instr_t ins;
      word_t  va;
      word_t  vb;
      word_t  res;
      wb_t    e;
      ins.op  = op;
      ins.rd  = reg_idx_t'(rd);
      ins.rs  = reg_idx_t'(rs);
      ins.rt  = reg_idx_t'(rt);
      ins.imm = imm[10:0];
      prog_buf[prog_len] = ins;
      prog_len++;
      va = model_regs[ins.rs];
      vb = model_regs[ins.rt];
      case (op)
         op_add:  res = va + vb;
         op_sub:  res = va - vb;
         op_and:  res = va & vb;
         op_or:   res = va | vb;
         op_addi: res = va + {{21{ins.imm[10]}}, ins.imm};
         op_mul:  res = va * vb;    // Low word of the product
         default: res = '0;
      endcase
      if (op inside {op_add, op_sub, op_and, op_or, op_addi, op_mul} && rd != 0) begin
         model_regs[rd] = res;
         e.valid = 1'b1;
         e.rd    = ins.rd;
         e.data  = res;
         exp_q.push_back(e);
      end
   endtask

   // Load, start, then collect strobes until busy falls
   task automatic run_program(input string name);
      int idx;
      int n_wb;
      int n_exp;
      n_wb  = 0;
      n_exp = exp_q.size();
      cycle_limit += 40 * prog_len;
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         prog.valid = 1'b1;
         prog.addr  = pc_t'(i);
         prog.instr = prog_buf[i];
      end
      @(posedge clk);
      #1;
      prog.valid = 1'b0;
      start      = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      check_busy(busy, 1'b1);
      while (busy) begin
         @(posedge clk);
         #1;
         if (wb.valid) begin
            n_wb++;
            idx = -1;
            for (int k = exp_q.size() - 1; k >= 0; k--) begin
               if (exp_q[k].rd == wb.rd) idx = k;   // Oldest pending write to rd
            end
            if (!busy || wb.rd == '0 || idx < 0) begin
               n_other_err++;
               $display("%s: unexpected write to register %0d, busy %0d", name, wb.rd, busy);
            end else begin
               check_wb("wb", wb, exp_q[idx]);
               exp_q.delete(idx);
            end
         end
      end
      if (n_wb != n_exp) begin
         n_other_err++;
         $display("%s: saw %0d write-backs but expected %0d", name, n_wb, n_exp);
      end
      $display("%s: %0d write-backs", name, n_wb);
      exp_q.delete();
      prog_len = 0;
   endtask

   task automatic test_reset_idle();
      wb_t idle;
      idle = '0;
      repeat (5) begin
         @(posedge clk);
         #1;
         check_busy(busy, 1'b0);
         check_wb("wb", wb, idle);
      end
   endtask

   task automatic test_alu_chain();
      put_instr(op_addi, 1, 0, 0, 5);
      put_instr(op_addi, 2, 0, 0, -3);
      put_instr(op_add, 3, 1, 2, 0);
      put_instr(op_sub, 4, 3, 1, 0);
      put_instr(op_and, 5, 4, 2, 0);
      put_instr(op_or, 6, 5, 3, 0);
      put_instr(op_addi, 7, 6, 0, -1024);   // Most negative immediate
      put_instr(op_addi, 8, 7, 0, 1023);
      put_instr(op_add, 8, 8, 8, 0);
      put_instr(op_halt, 0, 0, 0, 0);
      run_program("alu chain");
   endtask

   task automatic test_mul_chain();
      put_instr(op_addi, 1, 0, 0, 3);
      put_instr(op_addi, 2, 0, 0, -7);
      put_instr(op_mul, 3, 1, 2, 0);
      put_instr(op_mul, 4, 3, 1, 0);
      put_instr(op_mul, 5, 4, 3, 0);
      put_instr(op_add, 6, 5, 1, 0);
      put_instr(op_addi, 11, 0, 0, -1);
      put_instr(op_mul, 12, 2, 11, 0);      // All four byte slices nonzero
      put_instr(op_mul, 13, 12, 12, 0);
      put_instr(op_halt, 0, 0, 0, 0);
      run_program("mul chain");
   endtask

   task automatic test_mul_spacing();
      for (int s = 0; s <= 5; s++) begin
         put_instr(op_mul, 20, 3, 2, 0);
         for (int k = 0; k < s; k++) begin
            put_instr(op_nop, 0, 0, 0, 0);
         end
         put_instr(op_addi, 21, 0, 0, s + 1);
         put_instr(op_or, 22, 1, 2, 0);
         put_instr(op_add, 23, 21, 22, 0);
      end
      put_instr(op_halt, 0, 0, 0, 0);
      run_program("mul spacing");
   endtask

   task automatic test_reg_zero();
      put_instr(op_addi, 0, 0, 0, 77);
      put_instr(op_mul, 0, 1, 2, 0);
      put_instr(op_add, 24, 0, 0, 0);
      put_instr(op_addi, 25, 0, 0, -9);
      put_instr(op_or, 26, 0, 25, 0);
      put_instr(op_halt, 0, 0, 0, 0);
      run_program("register zero");
   endtask

   task automatic test_random_prog();
      int      r;
      opcode_e op;
      for (int i = 0; i < 39; i++) begin
         r = $random(seed);
         case (r[2:0])
            3'd0:    op = op_nop;
            3'd1:    op = op_add;
            3'd2:    op = op_sub;
            3'd3:    op = op_and;
            3'd4:    op = op_or;
            3'd5:    op = op_addi;
            default: op = op_mul;
         endcase
         // Eight registers only, so hazards are frequent
         put_instr(op, r[10:8], r[13:11], r[16:14], r[27:17]);
      end
      put_instr(op_halt, 0, 0, 0, 0);
      run_program("random program");
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt <= cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the program never drained", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      if_id_reset = 1'b1;
      start       = 1'b0;
      prog        = '0;
      prog_len    = 0;
      seed        = 32'haa7a;
      n_value_err = 0;
      n_other_err = 0;
      repeat (10) @(posedge clk);
      #1;
      if_id_reset = 1'b0;
      test_reset_idle();
      test_alu_chain();
      test_mul_chain();
      test_mul_spacing();
      test_reg_zero();
      test_random_prog();
      $display("Errors: %0d wrong values, %0d other failures", n_value_err, n_other_err);
      if (n_value_err + n_other_err == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* all.f */
core_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
issue_control.sv
alu_stage.sv
mult_pipe.sv
core_top.sv
core_checker.sv
tb_core.sv

/* Makefile */
TOP = tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module core_top core_pkg.sv reg_file.sv fetch_stage.sv \
		decode_stage.sv issue_control.sv alu_stage.sv mult_pipe.sv core_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f \
		--Mdir obj_dir -o sim_core
	./obj_dir/sim_core > sim.log 2>&1 || true
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
